// File: hw/cam_consts.svh
// Frame, crop window, DMA transfer and FIFO depth constants

`ifndef CAM_CONSTS_SVH
`define CAM_CONSTS_SVH

// Incoming MIPI frame
`define CAM_FRAME_WIDTH 32
`define CAM_FRAME_HEIGHT 8

// Crop window with width and x offset in multiples of 4
`define CAM_CROP_WIDTH 16
`define CAM_CROP_HEIGHT 4
`define CAM_CROP_X_OFFSET 8
`define CAM_CROP_Y_OFFSET 2

// Beats per DMA transfer
`define CAM_DMA_TRANSFER_LENGTH 16

// Buffer depths
`define CAM_REMAP_FIFO_DEPTH 8
`define CAM_DMA_FIFO_DEPTH 32

`endif

// File: hw/cam_pkg.sv
// Pixel, pixel-group and debug-bundle types for the camera capture path

package cam_pkg;

   // One pixel after RAW10 truncation
   typedef logic [7:0] pixel_t;

   // Four pixels of one 4PPC beat with p0 as the leftmost
   typedef struct packed {
      pixel_t p3;
      pixel_t p2;
      pixel_t p1;
      pixel_t p0;
   } quad_pix_t;

   // Two pixels of one 2PPC beat with p0 as the left one
   typedef struct packed {
      pixel_t p1;
      pixel_t p0;
   } pair_pix_t;

   // Sticky FIFO error flags and traffic counters
   typedef struct packed {
      logic        remap_overflow;
      logic        remap_underflow;
      logic        dma_overflow;
      logic        dma_underflow;
      logic [31:0] dma_wcount;
      logic [31:0] dma_rcount;
   } debug_t;

endpackage

// File: hw/sync_fifo.sv
// Single-clock first-word-fall-through FIFO with overflow and underflow pulses

module sync_fifo #(
   parameter type payload_t = logic [7:0],
   parameter int  depth     = 8
) (
   input  logic     mipi_pclk,
   input  logic     rst_n,
   input  logic     wr_en,
   input  payload_t wdata,
   input  logic     rd_en,
   output payload_t rdata,
   output logic     empty,
   output logic     overflow,
   output logic     underflow
);

   localparam int aw = (depth > 1) ? $clog2(depth) : 1;
   localparam int cw = $clog2(depth + 1);

   payload_t        mem [depth];
   logic [aw-1:0]   wr_ptr;
   logic [aw-1:0]   rd_ptr;
   logic [cw-1:0]   count;
   logic            full;
   logic            do_wr;
   logic            do_rd;

   assign full  = (count == cw'(depth));
   assign empty = (count == '0);
   assign do_wr = wr_en & ~full;
   assign do_rd = rd_en & ~empty;

   // Head of the queue is always visible
   assign rdata = mem[rd_ptr];

   always_ff @(posedge mipi_pclk) begin
      if (do_wr) begin
         mem[wr_ptr] <= wdata;
      end
   end

   always_ff @(posedge mipi_pclk) begin
      if (!rst_n) begin
         wr_ptr    <= '0;
         rd_ptr    <= '0;
         count     <= '0;
         overflow  <= 1'b0;
         underflow <= 1'b0;
      end else begin
         if (do_wr) begin
            wr_ptr <= (wr_ptr == aw'(depth - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (do_rd) begin
            rd_ptr <= (rd_ptr == aw'(depth - 1)) ? '0 : rd_ptr + 1'b1;
         end
         count     <= count + cw'(do_wr) - cw'(do_rd);
         // A write into a full buffer is lost
         overflow  <= wr_en & full;
         underflow <= rd_en & empty;
      end
   end

endmodule

// File: hw/cam_input_stage.sv
// Camera input registers, 8-bit extraction, sync edges, position counters and crop window

`include "cam_consts.svh"

module cam_input_stage (
   input  logic               mipi_pclk,
   input  logic               rst_n,
   input  logic [63:0]        mipi_cam_data,
   input  logic               mipi_cam_valid,
   input  logic               mipi_cam_hs,
   input  logic               mipi_cam_vs,
   input  logic               capture_en,
   output cam_pkg::quad_pix_t quad_out,
   output logic               quad_valid,
   output logic               vs_fall
);

   // Column counter runs in 4-pixel groups
   localparam int x_w  = $clog2(`CAM_FRAME_WIDTH / 4 + 1);
   localparam int y_w  = $clog2(`CAM_FRAME_HEIGHT + 1);
   localparam int x_lo = `CAM_CROP_X_OFFSET / 4;
   localparam int x_hi = (`CAM_CROP_X_OFFSET + `CAM_CROP_WIDTH) / 4;
   localparam int y_lo = `CAM_CROP_Y_OFFSET;
   localparam int y_hi = `CAM_CROP_Y_OFFSET + `CAM_CROP_HEIGHT;

   logic [39:0]    cam_data;
   logic           cam_valid;
   logic           cam_hs;
   logic           cam_hs_r;
   logic           cam_vs;
   logic           cam_vs_r;
   logic           hs_fall;
   logic           in_window;
   logic [x_w-1:0] x_count;
   logic [y_w-1:0] y_count;

   ////////////////////////////////////////////////////////////
   // Input registers
   ////////////////////////////////////////////////////////////

   // Only the low 40 bits carry RAW10 pixels
   always_ff @(posedge mipi_pclk) begin
      cam_data <= mipi_cam_data[39:0];
   end

   always_ff @(posedge mipi_pclk) begin
      if (!rst_n) begin
         cam_valid <= 1'b0;
         cam_hs    <= 1'b0;
         cam_hs_r  <= 1'b0;
         cam_vs    <= 1'b0;
         cam_vs_r  <= 1'b0;
      end else begin
         cam_valid <= mipi_cam_valid;
         cam_hs    <= mipi_cam_hs;
         cam_hs_r  <= cam_hs;
         cam_vs    <= mipi_cam_vs;
         cam_vs_r  <= cam_vs;
      end
   end

   assign hs_fall = cam_hs_r & ~cam_hs;
   assign vs_fall = cam_vs_r & ~cam_vs;

   // Top 8 of each 10-bit pixel
   assign quad_out.p0 = cam_data[9:2];
   assign quad_out.p1 = cam_data[19:12];
   assign quad_out.p2 = cam_data[29:22];
   assign quad_out.p3 = cam_data[39:32];

   ////////////////////////////////////////////////////////////
   // Position counters and crop window
   ////////////////////////////////////////////////////////////

   always_ff @(posedge mipi_pclk) begin
      if (!rst_n) begin
         x_count <= '0;
         y_count <= '0;
      end else begin
         if (vs_fall || hs_fall) begin
            x_count <= '0;
         end else if (cam_valid) begin
            x_count <= x_count + 1'b1;
         end
         if (vs_fall) begin
            y_count <= '0;
         end else if (hs_fall) begin
            y_count <= y_count + 1'b1;
         end
      end
   end

   assign in_window = (x_count >= x_w'(x_lo)) && (x_count < x_w'(x_hi)) &&
                      (y_count >= y_w'(y_lo)) && (y_count < y_w'(y_hi));

   assign quad_valid = cam_valid & in_window & capture_en;

endmodule

// File: hw/capture_control.sv
// Trigger synchronizer and one-frame capture window

module capture_control (
   input  logic mipi_pclk,
   input  logic rst_n,
   input  logic trigger_capture_frame,
   input  logic vs_fall,
   output logic capture_en
);

   logic trig_r1;
   logic trig_r2;
   logic trig_r3;
   logic trig_rise;
   logic trig_hold;

   assign trig_rise = trig_r2 & ~trig_r3;

   always_ff @(posedge mipi_pclk) begin
      if (!rst_n) begin
         trig_r1    <= 1'b0;
         trig_r2    <= 1'b0;
         trig_r3    <= 1'b0;
         trig_hold  <= 1'b0;
         capture_en <= 1'b0;
      end else begin
         trig_r1 <= trigger_capture_frame;
         trig_r2 <= trig_r1;
         trig_r3 <= trig_r2;

         // Request waits here until the next frame boundary
         if (trig_rise) begin
            trig_hold <= 1'b1;
         end else if (vs_fall) begin
            trig_hold <= 1'b0;
         end

         // Open on the first vsync fall after a request, close on the next one
         if (trig_hold && vs_fall) begin
            capture_en <= 1'b1;
         end else if (capture_en && vs_fall) begin
            capture_en <= 1'b0;
         end
      end
   end

endmodule

// File: hw/pixel_remap_4to2.sv
// 4PPC buffer FIFO and split into 2PPC pixel pairs

`include "cam_consts.svh"

module pixel_remap_4to2 (
   input  logic               mipi_pclk,
   input  logic               rst_n,
   input  cam_pkg::quad_pix_t quad_in,
   input  logic               quad_valid,
   output cam_pkg::pair_pix_t pair_out,
   output logic               pair_valid,
   output logic               overflow,
   output logic               underflow
);

   import cam_pkg::*;

   quad_pix_t head;
   pair_pix_t hi_pair;
   logic      fifo_empty;
   logic      phase;
   logic      pop;
   logic      pop_r;

   sync_fifo #(
      .payload_t (quad_pix_t),
      .depth     (`CAM_REMAP_FIFO_DEPTH)
   ) i_remap_fifo (
      .mipi_pclk (mipi_pclk),
      .rst_n     (rst_n),
      .wr_en     (quad_valid),
      .wdata     (quad_in),
      .rd_en     (pop),
      .rdata     (head),
      .empty     (fifo_empty),
      .overflow  (overflow),
      .underflow (underflow)
   );

   // Pop at most every other cycle since each quad gives two output beats
   assign pop = phase & ~fifo_empty;

   always_ff @(posedge mipi_pclk) begin
      if (!rst_n) begin
         phase <= 1'b0;
         pop_r <= 1'b0;
      end else begin
         phase <= ~phase;
         pop_r <= pop;
      end
   end

   // Right half waits one cycle
   always_ff @(posedge mipi_pclk) begin
      hi_pair.p0 <= head.p2;
      hi_pair.p1 <= head.p3;
   end

   assign pair_valid  = pop | pop_r;
   assign pair_out.p0 = pop ? head.p0 : hi_pair.p0;
   assign pair_out.p1 = pop ? head.p1 : hi_pair.p1;

endmodule

// File: hw/dma_writer.sv
// DMA FIFO, init synchronizer, write enable, beat counter and last flag

`include "cam_consts.svh"

module dma_writer (
   input  logic               mipi_pclk,
   input  logic               rst_n,
   input  cam_pkg::pair_pix_t pair_in,
   input  logic               pair_valid,
   input  logic               cam_dma_init_done,
   input  logic               cam_dma_wready,
   output logic               cam_dma_wvalid,
   output logic               cam_dma_wlast,
   output logic [63:0]        cam_dma_wdata,
   output logic               fifo_empty,
   output logic               write_en,
   output logic               overflow,
   output logic               underflow
);

   import cam_pkg::*;

   localparam int cnt_w = $clog2(`CAM_DMA_TRANSFER_LENGTH);

   pair_pix_t        head;
   logic             init_r1;
   logic             init_r2;
   logic             init_r3;
   logic             beat;
   logic [cnt_w-1:0] beat_count;

   sync_fifo #(
      .payload_t (pair_pix_t),
      .depth     (`CAM_DMA_FIFO_DEPTH)
   ) i_dma_fifo (
      .mipi_pclk (mipi_pclk),
      .rst_n     (rst_n),
      .wr_en     (pair_valid),
      .wdata     (pair_in),
      .rd_en     (beat),
      .rdata     (head),
      .empty     (fifo_empty),
      .overflow  (overflow),
      .underflow (underflow)
   );

   // Offered whenever enabled and data is waiting
   assign cam_dma_wvalid = write_en & ~fifo_empty;
   assign beat           = cam_dma_wvalid & cam_dma_wready;
   assign cam_dma_wlast  = cam_dma_wvalid &
                           (beat_count == cnt_w'(`CAM_DMA_TRANSFER_LENGTH - 1));

   // Left pixel in the low word, right pixel in the high word
   assign cam_dma_wdata = {24'd0, head.p1, 24'd0, head.p0};

   always_ff @(posedge mipi_pclk) begin
      if (!rst_n) begin
         init_r1    <= 1'b0;
         init_r2    <= 1'b0;
         init_r3    <= 1'b0;
         write_en   <= 1'b0;
         beat_count <= '0;
      end else begin
         init_r1 <= cam_dma_init_done;
         init_r2 <= init_r1;
         init_r3 <= init_r2;
         // One transfer per init rising edge
         if (init_r2 && !init_r3) begin
            write_en <= 1'b1;
         end else if (beat && cam_dma_wlast) begin
            write_en <= 1'b0;
         end
         if (beat) begin
            beat_count <= cam_dma_wlast ? '0 : beat_count + 1'b1;
         end
      end
   end

endmodule

// File: hw/cam_debug_regs.sv
// Sticky FIFO error flags, pair and beat counters, DMA status word

module cam_debug_regs (
   input  logic              mipi_pclk,
   input  logic              rst_n,
   input  logic              remap_overflow,
   input  logic              remap_underflow,
   input  logic              dma_overflow,
   input  logic              dma_underflow,
   input  logic              pair_valid,
   input  logic              dma_beat,
   input  logic              fifo_empty,
   input  logic              write_en,
   input  logic              cam_dma_wready,
   output cam_pkg::debug_t   debug,
   output logic [31:0]       debug_cam_dma_status
);

   logic beat_done;

   // dma_beat carries the offered wvalid and a beat completes with wready
   assign beat_done = dma_beat & cam_dma_wready;

   always_ff @(posedge mipi_pclk) begin
      if (!rst_n) begin
         debug <= '0;
      end else begin
         debug.remap_overflow  <= debug.remap_overflow | remap_overflow;
         debug.remap_underflow <= debug.remap_underflow | remap_underflow;
         debug.dma_overflow    <= debug.dma_overflow | dma_overflow;
         debug.dma_underflow   <= debug.dma_underflow | dma_underflow;
         if (pair_valid) begin
            debug.dma_wcount <= debug.dma_wcount + 32'd1;
         end
         if (beat_done) begin
            debug.dma_rcount <= debug.dma_rcount + 32'd1;
         end
      end
   end

   assign debug_cam_dma_status = {29'd0, fifo_empty, write_en, cam_dma_wready};

endmodule

// File: hw/cam_capture_top.sv
// Capture front end top level connecting input stage, capture control, remap, DMA and debug

module cam_capture_top (
   input  logic            mipi_pclk,
   input  logic            rst_n,
   input  logic [63:0]     mipi_cam_data,
   input  logic            mipi_cam_valid,
   input  logic            mipi_cam_hs,
   input  logic            mipi_cam_vs,
   input  logic            trigger_capture_frame,
   input  logic            cam_dma_init_done,
   input  logic            cam_dma_wready,
   output logic            cam_dma_wvalid,
   output logic [63:0]     cam_dma_wdata,
   output logic            cam_dma_wlast,
   output cam_pkg::debug_t debug,
   output logic [31:0]     debug_cam_dma_status
);

   import cam_pkg::*;

   quad_pix_t quad;
   pair_pix_t pair;
   logic      quad_valid;
   logic      pair_valid;
   logic      vs_fall;
   logic      capture_en;
   logic      remap_overflow;
   logic      remap_underflow;
   logic      dma_overflow;
   logic      dma_underflow;
   logic      fifo_empty;
   logic      write_en;

   ////////////////////////////////////////////////////////////
   // Pixel path
   ////////////////////////////////////////////////////////////

   cam_input_stage i_input_stage (
      .mipi_pclk      (mipi_pclk),
      .rst_n          (rst_n),
      .mipi_cam_data  (mipi_cam_data),
      .mipi_cam_valid (mipi_cam_valid),
      .mipi_cam_hs    (mipi_cam_hs),
      .mipi_cam_vs    (mipi_cam_vs),
      .capture_en     (capture_en),
      .quad_out       (quad),
      .quad_valid     (quad_valid),
      .vs_fall        (vs_fall)
   );

   capture_control i_capture_control (
      .mipi_pclk             (mipi_pclk),
      .rst_n                 (rst_n),
      .trigger_capture_frame (trigger_capture_frame),
      .vs_fall               (vs_fall),
      .capture_en            (capture_en)
   );

   pixel_remap_4to2 i_remap (
      .mipi_pclk  (mipi_pclk),
      .rst_n      (rst_n),
      .quad_in    (quad),
      .quad_valid (quad_valid),
      .pair_out   (pair),
      .pair_valid (pair_valid),
      .overflow   (remap_overflow),
      .underflow  (remap_underflow)
   );

   ////////////////////////////////////////////////////////////
   // DMA stream and debug
   ////////////////////////////////////////////////////////////

   dma_writer i_dma_writer (
      .mipi_pclk         (mipi_pclk),
      .rst_n             (rst_n),
      .pair_in           (pair),
      .pair_valid        (pair_valid),
      .cam_dma_init_done (cam_dma_init_done),
      .cam_dma_wready    (cam_dma_wready),
      .cam_dma_wvalid    (cam_dma_wvalid),
      .cam_dma_wlast     (cam_dma_wlast),
      .cam_dma_wdata     (cam_dma_wdata),
      .fifo_empty        (fifo_empty),
      .write_en          (write_en),
      .overflow          (dma_overflow),
      .underflow         (dma_underflow)
   );

   cam_debug_regs i_debug_regs (
      .mipi_pclk            (mipi_pclk),
      .rst_n                (rst_n),
      .remap_overflow       (remap_overflow),
      .remap_underflow      (remap_underflow),
      .dma_overflow         (dma_overflow),
      .dma_underflow        (dma_underflow),
      .pair_valid           (pair_valid),
      .dma_beat             (cam_dma_wvalid),
      .fifo_empty           (fifo_empty),
      .write_en             (write_en),
      .cam_dma_wready       (cam_dma_wready),
      .debug                (debug),
      .debug_cam_dma_status (debug_cam_dma_status)
   );

endmodule

// File: test/cam_checker.sv
// DMA stream monitor comparing beats against an expected word queue

`include "cam_consts.svh"

module cam_checker (
   input  logic        mipi_pclk,
   input  logic        rst_n,
   input  logic        cam_dma_wvalid,
   input  logic        cam_dma_wready,
   input  logic [63:0] cam_dma_wdata,
   input  logic        cam_dma_wlast,
   input  logic        hold_off,
   input  logic        expect_push,
   input  logic [63:0] expect_word,
   output int          error_count,
   output int          beat_count,
   output int          pending
);

   logic [63:0] expected_q [$];
   logic [63:0] last_data;
   logic        stalled;
   logic [63:0] want;
   logic        want_last;

   initial begin
      error_count = 0;
      beat_count  = 0;
      pending     = 0;
      stalled     = 1'b0;
      last_data   = '0;
   end

   always @(posedge mipi_pclk) begin
      if (!rst_n) begin
         expected_q.delete();
         stalled     = 1'b0;
         beat_count  = 0;
      end else begin
         if (expect_push) begin
            expected_q.push_back(expect_word);
         end

         // DMA must stay silent until its first init edge
         if (hold_off && cam_dma_wvalid) begin
            $display("wvalid was raised before the DMA init edge");
            error_count++;
         end

         // An offered word must stay put until it is taken
         if (stalled && (!cam_dma_wvalid || cam_dma_wdata != last_data)) begin
            $display("DMA word changed or was withdrawn while wready was low");
            error_count++;
         end

         if (cam_dma_wvalid && cam_dma_wready) begin
            want_last = ((beat_count % `CAM_DMA_TRANSFER_LENGTH) ==
                         `CAM_DMA_TRANSFER_LENGTH - 1);
            if (expected_q.size() == 0) begin
               $display("DMA beat %0d arrived with no expected data", beat_count);
               error_count++;
            end else begin
               want = expected_q.pop_front();
               if (cam_dma_wdata != want) begin
                  $display("** Error: cam_dma_wdata got %h expected %h at beat %0d",
                           cam_dma_wdata, want, beat_count);
                  error_count++;
               end
            end
            if (cam_dma_wlast != want_last) begin
               $display("** Error: cam_dma_wlast got %h expected %h at beat %0d",
                        cam_dma_wlast, want_last, beat_count);
               error_count++;
            end
            beat_count++;
         end

         stalled   = cam_dma_wvalid & ~cam_dma_wready;
         last_data = cam_dma_wdata;
      end
      pending = expected_q.size();
   end

endmodule

// File: test/tb_cam_capture.sv
// Capture front end testbench with clock, reset, frame stimulus, LFSR, reference and tests

`include "cam_consts.svh"

module tb_cam_capture;

   import cam_pkg::*;

   logic        mipi_pclk;
   logic        rst_n;
   logic [63:0] mipi_cam_data;
   logic        mipi_cam_valid;
   logic        mipi_cam_hs;
   logic        mipi_cam_vs;
   logic        trigger_capture_frame;
   logic        cam_dma_init_done;
   logic        cam_dma_wready;
   logic        cam_dma_wvalid;
   logic [63:0] cam_dma_wdata;
   logic        cam_dma_wlast;
   debug_t      debug;
   logic [31:0] debug_cam_dma_status;

   logic        hold_off;
   logic        expect_push;
   logic [63:0] expect_word;
   int          checker_errors;
   int          beats;
   int          pending;

   int          tb_errors;
   int          err_base;
   int          tests_failed;
   int          frame_no;
   int          base;
   int          wready_mode;
   logic [31:0] lfsr_state;

   cam_capture_top i_dut (
      .mipi_pclk             (mipi_pclk),
      .rst_n                 (rst_n),
      .mipi_cam_data         (mipi_cam_data),
      .mipi_cam_valid        (mipi_cam_valid),
      .mipi_cam_hs           (mipi_cam_hs),
      .mipi_cam_vs           (mipi_cam_vs),
      .trigger_capture_frame (trigger_capture_frame),
      .cam_dma_init_done     (cam_dma_init_done),
      .cam_dma_wready        (cam_dma_wready),
      .cam_dma_wvalid        (cam_dma_wvalid),
      .cam_dma_wdata         (cam_dma_wdata),
      .cam_dma_wlast         (cam_dma_wlast),
      .debug                 (debug),
      .debug_cam_dma_status  (debug_cam_dma_status)
   );

   cam_checker i_checker (
      .mipi_pclk      (mipi_pclk),
      .rst_n          (rst_n),
      .cam_dma_wvalid (cam_dma_wvalid),
      .cam_dma_wready (cam_dma_wready),
      .cam_dma_wdata  (cam_dma_wdata),
      .cam_dma_wlast  (cam_dma_wlast),
      .hold_off       (hold_off),
      .expect_push    (expect_push),
      .expect_word    (expect_word),
      .error_count    (checker_errors),
      .beat_count     (beats),
      .pending        (pending)
   );

   initial begin
      mipi_pclk = 1'b0;
      forever #50 mipi_pclk = ~mipi_pclk;
   end

   ////////////////////////////////////////////////////////////
   // Reference model and random source
   ////////////////////////////////////////////////////////////

   // RAW10 value of one camera pixel
   function automatic logic [9:0] ref_pixel(input int frame, input int x, input int y);
      logic [9:0] v;
      v = 10'(x * 37 + y * 113 + frame * 71);
      v = v ^ 10'(x << 5) ^ 10'(y << 7);
      return v;
   endfunction

   // DMA word for the pair starting at column x
   function automatic logic [63:0] expected_word(input int frame, input int x, input int y);
      logic [9:0] left;
      logic [9:0] right;
      left  = ref_pixel(frame, x, y);
      right = ref_pixel(frame, x + 1, y);
      return {24'd0, right[9:2], 24'd0, left[9:2]};
   endfunction

   // Taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      logic fb;
      fb = s[31] ^ s[21] ^ s[1] ^ s[0];
      return {s[30:0], fb};
   endfunction

   // Drives wready low, high or from the LFSR for modes 0, 1 and 2
   always @(negedge mipi_pclk) begin
      if (wready_mode == 2) begin
         lfsr_state     = lfsr_next(lfsr_state);
         cam_dma_wready <= lfsr_state[0];
      end else begin
         cam_dma_wready <= (wready_mode == 1);
      end
   end

   ////////////////////////////////////////////////////////////
   // Stimulus and wait tasks
   ////////////////////////////////////////////////////////////

   task automatic idle(input int n);
      repeat (n) @(negedge mipi_pclk);
   endtask

   task automatic timeout_fail(input string what);
      $display("timeout while waiting for %s", what);
      $display("STATUS: FAIL");
      $finish;
   endtask

   task automatic vs_pulse();
      @(negedge mipi_pclk);
      mipi_cam_vs = 1'b1;
      idle(3);
      mipi_cam_vs = 1'b0;
      idle(2);
   endtask

   task automatic send_line(input int frame, input int y);
      logic [39:0] word;
      @(negedge mipi_pclk);
      mipi_cam_hs = 1'b1;
      for (int q = 0; q < `CAM_FRAME_WIDTH / 4; q++) begin
         for (int i = 0; i < 4; i++) begin
            word[10*i +: 10] = ref_pixel(frame, 4 * q + i, y);
         end
         @(negedge mipi_pclk);
         mipi_cam_valid = 1'b1;
         mipi_cam_data  = {24'd0, word};
         @(negedge mipi_pclk);
         mipi_cam_valid = 1'b0;
      end
      @(negedge mipi_pclk);
      mipi_cam_hs = 1'b0;
      idle(3);
   endtask

   // Leading vsync pulse then all lines of the frame
   task automatic send_frame();
      int frame;
      frame = frame_no;
      frame_no++;
      vs_pulse();
      idle(4);
      for (int y = 0; y < `CAM_FRAME_HEIGHT; y++) begin
         send_line(frame, y);
      end
      idle(4);
   endtask

   task automatic push_frame_expect(input int frame);
      for (int y = `CAM_CROP_Y_OFFSET; y < `CAM_CROP_Y_OFFSET + `CAM_CROP_HEIGHT; y++) begin
         for (int x = `CAM_CROP_X_OFFSET; x < `CAM_CROP_X_OFFSET + `CAM_CROP_WIDTH;
              x += 2) begin
            @(negedge mipi_pclk);
            expect_push = 1'b1;
            expect_word = expected_word(frame, x, y);
         end
      end
      @(negedge mipi_pclk);
      expect_push = 1'b0;
   endtask

   task automatic pulse_trigger();
      @(negedge mipi_pclk);
      trigger_capture_frame = 1'b1;
      idle(6);
      trigger_capture_frame = 1'b0;
      idle(2);
   endtask

   task automatic arm_dma();
      @(negedge mipi_pclk);
      cam_dma_init_done = 1'b0;
      idle(5);
      cam_dma_init_done = 1'b1;
   endtask

   task automatic wait_beats(input int target);
      int cycles;
      cycles = 0;
      while (beats < target && cycles < 3000) begin
         @(negedge mipi_pclk);
         cycles++;
      end
      if (beats < target) timeout_fail("DMA beats");
   endtask

   task automatic wait_write_en(input logic value);
      int cycles;
      cycles = 0;
      while (debug_cam_dma_status[1] != value && cycles < 3000) begin
         @(negedge mipi_pclk);
         cycles++;
      end
      if (debug_cam_dma_status[1] != value) timeout_fail("DMA write enable");
   endtask

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] want);
      if (got !== want) begin
         $display("** Error: %s got %h expected %h", name, got, want);
         tb_errors++;
      end
   endtask

   // Two transfers of one frame with a DMA re-arm between them
   task automatic collect_frame(input int start, input logic armed);
      if (!armed) arm_dma();
      wait_beats(start + `CAM_DMA_TRANSFER_LENGTH);
      wait_write_en(1'b0);
      arm_dma();
      wait_beats(start + 2 * `CAM_DMA_TRANSFER_LENGTH);
      wait_write_en(1'b0);
      idle(5);
      check_value("dma beat count", 32'(beats), 32'(start + 32));
      check_value("expected words left", 32'(pending), 32'd0);
   endtask

   task automatic end_test(input int num, input string name);
      int errs;
      errs = tb_errors + checker_errors - err_base;
      if (errs == 0) begin
         $display("test %0d %s: ok", num, name);
      end else begin
         $display("test %0d %s: failed with %0d errors", num, name, errs);
         tests_failed++;
      end
      err_base = tb_errors + checker_errors;
   endtask

   ////////////////////////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////////////////////////

   initial begin
      rst_n                 = 1'b0;
      mipi_cam_data         = '0;
      mipi_cam_valid        = 1'b0;
      mipi_cam_hs           = 1'b0;
      mipi_cam_vs           = 1'b0;
      trigger_capture_frame = 1'b0;
      cam_dma_init_done     = 1'b0;
      cam_dma_wready        = 1'b0;
      hold_off              = 1'b1;
      expect_push           = 1'b0;
      expect_word           = '0;
      tb_errors             = 0;
      err_base              = 0;
      tests_failed          = 0;
      frame_no              = 0;
      wready_mode           = 1;
      lfsr_state            = 32'h0994_dd6a;
      idle(10);
      rst_n = 1'b1;
      idle(5);

      // Untriggered frames must not reach the DMA
      send_frame();
      send_frame();
      idle(20);
      check_value("debug.dma_wcount", debug.dma_wcount, 32'd0);
      check_value("debug.dma_rcount", debug.dma_rcount, 32'd0);
      end_test(2, "no capture without trigger");

      // Data waits in the FIFO until the first init edge
      push_frame_expect(frame_no);
      pulse_trigger();
      send_frame();
      vs_pulse();
      idle(20);
      check_value("debug_cam_dma_status", debug_cam_dma_status, 32'h1);
      hold_off = 1'b0;
      collect_frame(0, 1'b0);
      end_test(1, "DMA init gating");

      // Streaming capture with the DMA armed ahead
      base = beats;
      push_frame_expect(frame_no);
      arm_dma();
      pulse_trigger();
      send_frame();
      vs_pulse();
      collect_frame(base, 1'b1);
      end_test(3, "one frame, full rate");

      wready_mode = 2;
      base = beats;
      push_frame_expect(frame_no);
      pulse_trigger();
      send_frame();
      vs_pulse();
      collect_frame(base, 1'b0);
      check_value("debug.dma_overflow", 32'(debug.dma_overflow), 32'd0);
      check_value("debug.remap_overflow", 32'(debug.remap_overflow), 32'd0);
      end_test(4, "random wready");

      wready_mode = 1;
      idle(3);
      check_value("debug.dma_wcount", debug.dma_wcount, 32'd96);
      check_value("debug.dma_rcount", debug.dma_rcount, 32'd96);
      check_value("debug_cam_dma_status", debug_cam_dma_status, 32'h5);
      arm_dma();
      wait_write_en(1'b1);
      check_value("debug_cam_dma_status", debug_cam_dma_status, 32'h7);
      wready_mode = 0;
      idle(3);
      check_value("debug_cam_dma_status", debug_cam_dma_status, 32'h6);
      end_test(5, "debug counters and status");

      // Two frames into a stalled DMA where only the first one fits
      push_frame_expect(frame_no);
      pulse_trigger();
      send_frame();
      pulse_trigger();
      send_frame();
      vs_pulse();
      idle(10);
      check_value("debug.dma_overflow", 32'(debug.dma_overflow), 32'd1);
      check_value("debug.remap_overflow", 32'(debug.remap_overflow), 32'd0);
      check_value("debug.remap_underflow", 32'(debug.remap_underflow), 32'd0);
      check_value("debug.dma_underflow", 32'(debug.dma_underflow), 32'd0);
      check_value("debug_cam_dma_status", debug_cam_dma_status, 32'h2);
      check_value("cam_dma_wvalid", 32'(cam_dma_wvalid), 32'd1);
      wready_mode = 1;
      base = beats;
      collect_frame(base, 1'b1);
      check_value("debug.dma_overflow", 32'(debug.dma_overflow), 32'd1);
      check_value("debug.dma_wcount", debug.dma_wcount, 32'd160);
      check_value("debug.dma_rcount", debug.dma_rcount, 32'd128);
      end_test(6, "DMA overflow under back-pressure");

      $display("tests run 6, tests failed %0d, errors %0d, beats %0d",
               tests_failed, tb_errors + checker_errors, beats);
      if (tests_failed == 0 && tb_errors + checker_errors == 0) begin
         $display("STATUS: PASS");
      end else begin
         $display("STATUS: FAIL");
      end
      $finish;
   end

endmodule

// File: flist.f
+incdir+hw
hw/cam_pkg.sv
hw/sync_fifo.sv
hw/cam_input_stage.sv
hw/capture_control.sv
hw/pixel_remap_4to2.sv
hw/dma_writer.sv
hw/cam_debug_regs.sv
hw/cam_capture_top.sv
test/cam_checker.sv
test/tb_cam_capture.sv

// File: Makefile
TOP = tb_cam_capture

all: run

build:
	verilator --binary --timing -f flist.f --top-module $(TOP) -Mdir obj_dir -o sim

run: build
	./obj_dir/sim | tee sim.log
	grep -q "STATUS: PASS" sim.log

lint:
	verilator --lint-only --timing -f flist.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean
